//--- all.f
+incdir+.
sd_resp_pkg.sv
sd_stream_pkg.sv
sd_bit_receiver.sv
sd_rx_fifo.sv
sd_response_decoder.sv
sd_receive_top.sv
sd_receive_chk.sv
sd_receive_tb.sv

//--- Bender.yml
package:
  name: sd_receive

sources:
  - include_dirs:
      - .
    files:
      - sd_resp_pkg.sv
      - sd_stream_pkg.sv
      - sd_bit_receiver.sv
      - sd_rx_fifo.sv
      - sd_response_decoder.sv
      - sd_receive_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - sd_receive_chk.sv
      - sd_receive_tb.sv

//--- sd_receive_tb.sv
`default_nettype none

`include "sd_params.svh"

module sd_receive_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import sd_resp_pkg::*;

  // Ones the card keeps sending after a reply
  localparam int TRAIL = 4;
  localparam int NROWS = 8;

  typedef struct {
    string       name;
    sd_resp_kind kind;
    int          filler;
    logic [7:0]  r1;
    logic [39:0] word;
    logic        bad_crc;
    logic        stall;
    int          busy;
  } row_t;

  logic        clock;
  logic        reset;
  logic        req_valid;
  sd_resp_kind req_kind;
  logic        req_ready;
  logic        miso;
  logic        sclk_en;
  logic        r1_valid;
  logic [7:0]  r1_status;
  logic        r37_valid;
  sd_r37_u     r37_word;
  logic        data_valid;
  logic [7:0]  data_byte;
  logic        data_ready;
  logic        block_done;
  logic        crc_error;

  row_t        rows [NROWS];
  logic        bits [$];
  logic [7:0]  payload [$];
  logic        taken;
  logic        stall_on;
  logic [15:0] lfsr;
  int          cycles;
  int          limit;

  sd_receive_top sd_receive_top_i (.*);

  bind sd_rx_fifo sd_receive_chk sd_receive_chk_i (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // Fibonacci LFSR on x^16 + x^14 + x^13 + x^11 stepped once per bit
  function automatic logic [7:0] random_bits(input int n);
    logic [7:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      val = {val[6:0], lfsr[0]};
    end
    return val;
  endfunction

  // CCITT CRC16 over the payload MSB first from a zero start
  // Feedback goes into the x^12, x^5 and x^0 terms
  function automatic logic [15:0] crc16(input logic [7:0] data [$]);
    logic [15:0] c;
    logic        fb;
    c = '0;
    foreach (data[i]) begin
      for (int b = 7; b >= 0; b--) begin
        fb = c[15] ^ data[i][b];
        c = {c[14:12], c[11] ^ fb, c[10:5], c[4] ^ fb, c[3:0], fb};
      end
    end
    return c;
  endfunction

  function automatic int row_bits(input row_t row);
    int n;
    n = row.filler + row.busy + TRAIL;
    case (row.kind)
      resp_r37:   n += 40;
      resp_block: n += 24 + 8 * `SD_BLOCK_BYTES;
      default:    n += 8;
    endcase
    return n;
  endfunction

  task automatic push_bits(input logic [39:0] val, input int n);
    for (int i = n - 1; i >= 0; i--) begin
      bits.push_back(val[i]);
    end
  endtask

  task automatic build_card(input row_t row);
    logic [15:0] crc;
    bits.delete();
    payload.delete();
    push_bits('1, row.filler);
    case (row.kind)
      resp_r37: push_bits(row.word, 40);
      resp_block: begin
        push_bits(40'hFE, 8);
        repeat (`SD_BLOCK_BYTES) payload.push_back(random_bits(8));
        foreach (payload[i]) begin
          push_bits(40'(payload[i]), 8);
        end
        crc = crc16(payload);
        if (row.bad_crc) begin
          crc[5] = ~crc[5];
        end
        push_bits(40'(crc), 16);
      end
      default: push_bits(40'(row.r1), 8);
    endcase
    // Busy run of R1b is empty for the other kinds
    push_bits('0, row.busy);
    push_bits('1, TRAIL);
  endtask

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch %s crc_error: expected %b, actual %b", name, exp, act);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic check_r37(input string name, input sd_r37_u exp, input sd_r37_u act);
    logic [39:0] raw;
    raw = exp;
    if (act !== exp || act.r3.ocr !== raw[31:0] || act.r7.check_pattern !== raw[7:0] ||
        act.r7.r1 !== raw[39:32]) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  // Advances one clock cycle and drives all inputs on the falling edge
  task automatic tick();
    @(negedge clock);
    cycles++;
    if (cycles >= limit) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("sim failed");
      $fatal(1);
    end
    if (sd_receive_top_i.sd_rx_fifo_i.sd_receive_chk_i.fails != 0) begin
      fail_run("an assertion on the receive buffer failed");
    end
    // Card drops the bit taken at the last rising edge
    if (taken && bits.size() != 0) begin
      void'(bits.pop_front());
    end
    miso = (bits.size() != 0) ? bits[0] : 1'b1;
    taken = sclk_en;
    data_ready = stall_on ? (random_bits(4) == 8'h0F) : 1'b1;
  endtask

  task automatic run_row(input row_t row);
    int   got;
    logic seen;
    logic starved;
    got = 0;
    seen = 1'b0;
    starved = 1'b0;
    while (!req_ready) tick();
    build_card(row);
    stall_on = row.stall;
    req_kind = row.kind;
    req_valid = 1'b1;
    tick();
    req_valid = 1'b0;
    while (!(seen && req_ready)) begin
      if (req_ready && bits.size() > TRAIL) begin
        fail_run("req_ready came back before the reply and busy time were over");
      end
      // Card paused mid reply means no credit was left
      if (!sclk_en && !data_ready && !req_ready && bits.size() > TRAIL + 1) begin
        starved = 1'b1;
      end
      if (r1_valid) begin
        if (row.kind != resp_r1 && row.kind != resp_r1b) begin
          fail_run("r1_valid pulsed for a request that expects no R1 reply");
        end
        check_byte(row.name, row.r1, r1_status);
        seen = 1'b1;
      end
      if (r37_valid) begin
        if (row.kind != resp_r37) begin
          fail_run("r37_valid pulsed for a request that expects no R3/R7 reply");
        end
        check_r37(row.name, row.word, r37_word);
        seen = 1'b1;
      end
      if (data_valid && data_ready) begin
        if (got == `SD_BLOCK_BYTES) begin
          fail_run("more data bytes arrived than one block holds");
        end
        check_byte($sformatf("%s byte %0d", row.name, got), payload[got], data_byte);
        got++;
      end
      if (block_done) begin
        if (got != `SD_BLOCK_BYTES) begin
          fail_run("block_done arrived before the whole payload");
        end
        check_flag(row.name, row.bad_crc, crc_error);
        seen = 1'b1;
      end
      tick();
    end
    if (row.stall && !starved) begin
      fail_run("sclk_en never paused while data_ready was held low");
    end
    stall_on = 1'b0;
  endtask

  initial begin
    rows[0] = '{"r1_filler", resp_r1, 7, 8'h01, 40'h0, 1'b0, 1'b0, 0};
    rows[1] = '{"r3_ocr", resp_r37, 3, 8'h00, 40'h00_C0FF_8000, 1'b0, 1'b0, 0};
    rows[2] = '{"r7_echo", resp_r37, 5, 8'h00, 40'h01_0000_01AA, 1'b0, 1'b0, 0};
    rows[3] = '{"block_good", resp_block, 4, 8'h00, 40'h0, 1'b0, 1'b0, 0};
    rows[4] = '{"block_bad_crc", resp_block, 2, 8'h00, 40'h0, 1'b1, 1'b0, 0};
    rows[5] = '{"block_stall", resp_block, 3, 8'h00, 40'h0, 1'b0, 1'b1, 0};
    rows[6] = '{"r1b_busy", resp_r1b, 2, 8'h00, 40'h0, 1'b0, 1'b0, 20};
    rows[7] = '{"r1_after_busy", resp_r1, 1, 8'h05, 40'h0, 1'b0, 1'b0, 0};
    lfsr = 16'd75;
    cycles = 0;
    limit = 200;
    foreach (rows[i]) begin
      limit += 4 * row_bits(rows[i]);
    end
    reset = 1'b1;
    req_valid = 1'b0;
    req_kind = resp_r1;
    miso = 1'b1;
    data_ready = 1'b1;
    taken = 1'b0;
    stall_on = 1'b0;
    repeat (3) tick();
    reset = 1'b0;
    foreach (rows[i]) begin
      run_row(rows[i]);
    end
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sd_receive_chk.sv
`default_nettype none

`include "sd_params.svh"

module sd_receive_chk (
  input wire                                   clock,
  input wire                                   reset,
  input wire                                   push,
  input wire                                   pop,
  input wire [$clog2(`SD_FIFO_DEPTH + 1)-1:0]  count,
  input wire                                   credit_return
);
  timeunit 1ns;
  timeprecision 1ps;

  // Failed assertions so far
  int fails = 0;

  // Credits keep the producer away from a full buffer
  no_push_when_full: assert property (@(posedge clock) disable iff (reset)
    !(push && (count == `SD_FIFO_DEPTH)))
    else begin
      $error("push into a full receive buffer");
      fails++;
    end

  no_pop_when_empty: assert property (@(posedge clock) disable iff (reset)
    !(pop && (count == 0)))
    else begin
      $error("pop from an empty receive buffer");
      fails++;
    end

  // One credit back exactly one cycle after each pop
  credit_after_pop: assert property (@(posedge clock) disable iff (reset)
    pop |=> credit_return)
    else begin
      $error("credit_return missing one cycle after a pop");
      fails++;
    end

endmodule

`default_nettype wire

//--- sd_receive_top.sv
`default_nettype none

module sd_receive_top (
  input  wire                            clock,
  input  wire                            reset,
  input  wire                            req_valid,
  input  wire sd_resp_pkg::sd_resp_kind  req_kind,
  output logic                           req_ready,
  input  wire                            miso,
  output logic                           sclk_en,
  output logic                           r1_valid,
  output logic [7:0]                     r1_status,
  output logic                           r37_valid,
  output sd_resp_pkg::sd_r37_u           r37_word,
  output logic                           data_valid,
  output logic [7:0]                     data_byte,
  input  wire                            data_ready,
  output logic                           block_done,
  output logic                           crc_error
);
  import sd_stream_pkg::*;

  // Producer to buffer
  logic       push;
  sd_item_tag push_tag;
  logic [7:0] push_byte;
  logic       credit_return;

  // Buffer to decoder
  logic       head_valid;
  sd_item_tag head_tag;
  logic [7:0] head_byte;
  logic       pop;

  sd_bit_receiver sd_bit_receiver_i (
    .clock         (clock),
    .reset         (reset),
    .req_valid     (req_valid),
    .req_kind      (req_kind),
    .req_ready     (req_ready),
    .miso          (miso),
    .sclk_en       (sclk_en),
    .push          (push),
    .push_tag      (push_tag),
    .push_byte     (push_byte),
    .credit_return (credit_return)
  );

  sd_rx_fifo sd_rx_fifo_i (
    .clock         (clock),
    .reset         (reset),
    .push          (push),
    .push_tag      (push_tag),
    .push_byte     (push_byte),
    .pop           (pop),
    .head_valid    (head_valid),
    .head_tag      (head_tag),
    .head_byte     (head_byte),
    .credit_return (credit_return)
  );

  sd_response_decoder sd_response_decoder_i (
    .clock      (clock),
    .reset      (reset),
    .head_valid (head_valid),
    .head_tag   (head_tag),
    .head_byte  (head_byte),
    .pop        (pop),
    .r1_valid   (r1_valid),
    .r1_status  (r1_status),
    .r37_valid  (r37_valid),
    .r37_word   (r37_word),
    .data_valid (data_valid),
    .data_byte  (data_byte),
    .data_ready (data_ready),
    .block_done (block_done),
    .crc_error  (crc_error)
  );

endmodule

`default_nettype wire

//--- sd_response_decoder.sv
`default_nettype none

module sd_response_decoder (
  input  wire                             clock,
  input  wire                             reset,
  input  wire                             head_valid,
  input  wire sd_stream_pkg::sd_item_tag  head_tag,
  input  wire [7:0]                       head_byte,
  output logic                            pop,
  output logic                            r1_valid,
  output logic [7:0]                      r1_status,
  output logic                            r37_valid,
  output sd_resp_pkg::sd_r37_u            r37_word,
  output logic                            data_valid,
  output logic [7:0]                      data_byte,
  input  wire                             data_ready,
  output logic                            block_done,
  output logic                            crc_error
);
  import sd_stream_pkg::*;

  logic [2:0] r37_cnt;
  logic       take_r37;
  logic       take_data;

  always_comb begin
    pop = 1'b0;
    if (head_valid) begin
      case (head_tag)
        // Output register free or emptying this cycle
        tag_data:      pop = !data_valid || data_ready;
        // Last byte must leave before block_done
        tag_block_end: pop = !data_valid;
        default:       pop = 1'b1;
      endcase
    end
  end

  assign take_r37  = pop && (head_tag == tag_r37);
  assign take_data = pop && (head_tag == tag_data);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      r1_valid   <= 1'b0;
      r37_valid  <= 1'b0;
      r37_cnt    <= '0;
      data_valid <= 1'b0;
      block_done <= 1'b0;
    end else begin
      r1_valid   <= pop && (head_tag == tag_r1);
      block_done <= pop && (head_tag == tag_block_end);
      r37_valid  <= take_r37 && (r37_cnt == 3'd4);
      if (take_r37) begin
        r37_cnt <= (r37_cnt == 3'd4) ? 3'd0 : r37_cnt + 1'b1;
      end
      if (take_data) begin
        data_valid <= 1'b1;
      end else if (data_ready) begin
        data_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (pop && (head_tag == tag_r1)) begin
      r1_status <= head_byte;
    end
    // Shift up, oldest byte ends in the R1 field
    if (take_r37) begin
      r37_word <= {r37_word.r3.ocr, head_byte};
    end
    if (take_data) begin
      data_byte <= head_byte;
    end
    if (pop && (head_tag == tag_block_end)) begin
      crc_error <= head_byte[0];
    end
  end

endmodule

`default_nettype wire

//--- sd_rx_fifo.sv
`default_nettype none

`include "sd_params.svh"

module sd_rx_fifo (
  input  wire                             clock,
  input  wire                             reset,
  input  wire                             push,
  input  wire sd_stream_pkg::sd_item_tag  push_tag,
  input  wire [7:0]                       push_byte,
  input  wire                             pop,
  output logic                            head_valid,
  output sd_stream_pkg::sd_item_tag       head_tag,
  output logic [7:0]                      head_byte,
  output logic                            credit_return
);
  import sd_stream_pkg::*;

  localparam int PTR_W = (`SD_FIFO_DEPTH > 1) ? $clog2(`SD_FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(`SD_FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(`SD_FIFO_DEPTH - 1);

  sd_item_tag       tag_mem [`SD_FIFO_DEPTH];
  logic [7:0]       byte_mem [`SD_FIFO_DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;

  // Room is guaranteed by the producer's credits
  always_ff @(posedge clock) begin
    if (push) begin
      tag_mem[wr_ptr]  <= push_tag;
      byte_mem[wr_ptr] <= push_byte;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rd_ptr        <= '0;
      wr_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      end
      count         <= count + CNT_W'(push) - CNT_W'(pop);
      // Each freed entry goes back as one credit
      credit_return <= pop;
    end
  end

  assign head_valid = (count != '0);
  assign head_tag   = tag_mem[rd_ptr];
  assign head_byte  = byte_mem[rd_ptr];

endmodule

`default_nettype wire

//--- sd_bit_receiver.sv
`default_nettype none

`include "sd_params.svh"

module sd_bit_receiver (
  input  wire                            clock,
  input  wire                            reset,
  input  wire                            req_valid,
  input  wire sd_resp_pkg::sd_resp_kind  req_kind,
  output logic                           req_ready,
  input  wire                            miso,
  output logic                           sclk_en,
  output logic                           push,
  output sd_stream_pkg::sd_item_tag      push_tag,
  output logic [7:0]                     push_byte,
  input  wire                            credit_return
);
  import sd_resp_pkg::*;
  import sd_stream_pkg::*;

  localparam int CREDIT_W = $clog2(`SD_FIFO_DEPTH + 1);
  localparam int BYTE_W = $clog2(`SD_BLOCK_BYTES + 8);

  localparam logic [2:0] ST_IDLE       = 3'd0;
  localparam logic [2:0] ST_WAIT_START = 3'd1;
  localparam logic [2:0] ST_RECEIVE    = 3'd2;
  localparam logic [2:0] ST_CRC        = 3'd3;
  localparam logic [2:0] ST_BUSY       = 3'd4;
  localparam logic [2:0] ST_FINISH     = 3'd5;

  logic [2:0]          state;
  logic [CREDIT_W-1:0] credit;
  logic [3:0]          bit_cnt;
  logic [BYTE_W-1:0]   byte_cnt;
  logic [BYTE_W-1:0]   reply_bytes;
  sd_resp_kind         kind;
  sd_item_tag          data_tag;
  logic [7:0]          shift;
  logic [15:0]         crc;
  logic                accept;
  logic                byte_done;
  logic                last_byte;
  logic                spend;

  assign req_ready = (state == ST_IDLE);
  assign accept = req_valid && req_ready;

  // Card runs only while a pushed byte is sure to find room
  // Busy wait needs no room, nothing gets pushed
  assign sclk_en = (state == ST_BUSY) ||
                   (((state == ST_WAIT_START) || (state == ST_RECEIVE) ||
                     (state == ST_CRC)) && (credit != '0));

  assign byte_done = (state == ST_RECEIVE) && sclk_en && (bit_cnt == 4'd7);
  assign last_byte = (byte_cnt == reply_bytes - BYTE_W'(1));
  assign spend = byte_done || ((state == ST_FINISH) && (credit != '0));

  always_comb begin
    case (kind)
      resp_block: reply_bytes = BYTE_W'(`SD_BLOCK_BYTES);
      resp_r37:   reply_bytes = BYTE_W'(5);
      default:    reply_bytes = BYTE_W'(1);
    endcase
  end

  assign data_tag = (kind == resp_block) ? tag_data :
                    (kind == resp_r37)   ? tag_r37  : tag_r1;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state    <= ST_IDLE;
      credit   <= CREDIT_W'(`SD_FIFO_DEPTH);
      bit_cnt  <= '0;
      byte_cnt <= '0;
      push     <= 1'b0;
    end else begin
      push   <= spend;
      credit <= credit - CREDIT_W'(spend) + CREDIT_W'(credit_return);
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state    <= ST_WAIT_START;
            bit_cnt  <= '0;
            byte_cnt <= '0;
          end
        end
        ST_WAIT_START: begin
          // Token 0xFE ends at its zero, replies start with theirs
          if (sclk_en && !miso) begin
            state   <= ST_RECEIVE;
            bit_cnt <= (kind == resp_block) ? 4'd0 : 4'd1;
          end
        end
        ST_RECEIVE: begin
          if (sclk_en) begin
            if (bit_cnt == 4'd7) begin
              bit_cnt  <= '0;
              byte_cnt <= byte_cnt + 1'b1;
              if (last_byte) begin
                case (kind)
                  resp_block: state <= ST_CRC;
                  resp_r1b:   state <= ST_BUSY;
                  default:    state <= ST_IDLE;
                endcase
              end
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        ST_CRC: begin
          if (sclk_en) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd15) begin
              state <= ST_FINISH;
            end
          end
        end
        ST_BUSY: begin
          if (miso) begin
            state <= ST_IDLE;
          end
        end
        ST_FINISH: begin
          if (credit != '0) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      kind <= req_kind;
      crc  <= '0;
    end else if (sclk_en && ((state == ST_RECEIVE) || (state == ST_CRC))) begin
      // CCITT, x^16 + x^12 + x^5 + 1
      crc <= {crc[14:0], 1'b0} ^ ((crc[15] ^ miso) ? 16'h1021 : 16'h0000);
    end
    if (sclk_en) begin
      shift <= {shift[6:0], miso};
    end
    if (byte_done) begin
      push_byte <= {shift[6:0], miso};
      push_tag  <= data_tag;
    end else if (state == ST_FINISH) begin
      push_byte <= {7'd0, crc != 16'h0000};
      push_tag  <= tag_block_end;
    end
  end

endmodule

`default_nettype wire

//--- sd_stream_pkg.sv
`default_nettype none

package sd_stream_pkg;

  // Tag carried next to every byte in the receive buffer
  typedef enum logic [1:0] {
    // Whole one-byte reply
    tag_r1        = 2'd0,
    // One of five reply bytes, MSB first
    tag_r37       = 2'd1,
    // Block payload byte
    tag_data      = 2'd2,
    // End of block, bit 0 of the byte flags a bad CRC
    tag_block_end = 2'd3
  } sd_item_tag;

endpackage

`default_nettype wire

//--- sd_resp_pkg.sv
`default_nettype none

package sd_resp_pkg;

  // Reply the host expects after the command it just sent
  typedef enum logic [1:0] {
    resp_r1    = 2'd0,
    resp_r1b   = 2'd1,
    resp_r37   = 2'd2,
    resp_block = 2'd3
  } sd_resp_kind;

  // R3 reply to READ_OCR
  typedef struct packed {
    logic [7:0]  r1;
    logic [31:0] ocr;
  } sd_r3_t;

  // R7 reply to SEND_IF_COND
  typedef struct packed {
    logic [7:0]  r1;
    logic [3:0]  cmd_version;
    logic [15:0] reserved;
    logic [3:0]  voltage_accepted;
    logic [7:0]  check_pattern;
  } sd_r7_t;

  // Same five bytes on the wire, read as either reply
  typedef union packed {
    sd_r3_t r3;
    sd_r7_t r7;
  } sd_r37_u;

endpackage

`default_nettype wire

//--- sd_params.svh
`ifndef SD_PARAMS_SVH
`define SD_PARAMS_SVH

// Payload bytes in one data block, CRC16 not counted
`define SD_BLOCK_BYTES 16

// Entries in the receive buffer
// The producer starts with this many credits
`define SD_FIFO_DEPTH 4

`endif
